// ==== all.f ====
hw/mt_pkg.sv
hw/sram_1rw.sv
hw/mt_word_align.sv
hw/mt_map_table.sv
hw/mt_bank_alloc.sv
hw/mt_read_return.sv
hw/mt_1r2w_top.sv
tb/tb_clock.sv
tb/tb_mt_1r2w.sv

// ==== hw/mt_1r2w_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module mt_1r2w_top (
  input  logic                       clk,
  input  logic                       rst,
  input  logic                       read,
  input  logic [mt_pkg::BITADDR-1:0] rd_addr,
  input  logic                       wr0,
  input  logic [mt_pkg::BITADDR-1:0] wr0_addr,
  input  logic [mt_pkg::WIDTH-1:0]   wr0_din,
  input  logic                       wr1,
  input  logic [mt_pkg::BITADDR-1:0] wr1_addr,
  input  logic [mt_pkg::WIDTH-1:0]   wr1_din,
  output logic                       rd_vld,
  output logic [mt_pkg::WIDTH-1:0]   rd_dout,
  output logic                       ready
);
  import mt_pkg::*;

  mem_req_t            req       [NUM_REQ];
  logic [BITVROW-1:0]  rd_row    [NUM_REQ];
  map_row_t            map_row   [NUM_REQ];
  bank_cmd_t           cmd       [NUM_PBNK];
  logic [BITPBNK-1:0]  rd_pbnk;
  logic [NUM_WRPT-1:0] upd_vld;
  logic [BITVROW-1:0]  upd_row   [NUM_WRPT];
  map_row_t            upd_map   [NUM_WRPT];
  logic [WIDTH-1:0]    bank_word [NUM_PBNK];

  assign req[0] = '{vld: read, addr: rd_addr, data: '0};
  assign req[1] = '{vld: wr0, addr: wr0_addr, data: wr0_din};
  assign req[2] = '{vld: wr1, addr: wr1_addr, data: wr1_din};

  for (genvar i = 0; i < NUM_REQ; i++) begin : g_row
    assign rd_row[i] = req[i].addr[BITADDR-1:BITVBNK];  // upper bits give the virtual row
  end

  mt_map_table u_map_table (
    .clk     (clk),
    .rst     (rst),
    .rd_row  (rd_row),
    .map_out (map_row),
    .upd_vld (upd_vld),
    .upd_row (upd_row),
    .upd_map (upd_map),
    .ready   (ready)
  );

  mt_bank_alloc u_bank_alloc (
    .ready   (ready),
    .req     (req),
    .map_in  (map_row),
    .cmd     (cmd),
    .rd_pbnk (rd_pbnk),
    .upd_vld (upd_vld),
    .upd_row (upd_row),
    .upd_map (upd_map)
  );

  for (genvar b = 0; b < NUM_PBNK; b++) begin : g_bank
    logic               mem_read;
    logic               mem_write;
    logic [BITSROW-1:0] mem_addr;
    logic [PHYWDTH-1:0] mem_bw;
    logic [PHYWDTH-1:0] mem_din;
    logic [PHYWDTH-1:0] mem_dout;

    mt_word_align u_align (
      .clk       (clk),
      .cmd       (cmd[b]),
      .mem_read  (mem_read),
      .mem_write (mem_write),
      .mem_addr  (mem_addr),
      .mem_bw    (mem_bw),
      .mem_din   (mem_din),
      .mem_dout  (mem_dout),
      .dout      (bank_word[b])
    );

    sram_1rw u_sram (
      .clk   (clk),
      .read  (mem_read),
      .write (mem_write),
      .addr  (mem_addr),
      .bw    (mem_bw),
      .din   (mem_din),
      .dout  (mem_dout)
    );
  end

  mt_read_return u_read_return (
    .clk       (clk),
    .rst       (rst),
    .read_fire (ready && read),  // reads before the sweep ends are ignored
    .rd_pbnk   (rd_pbnk),
    .bank_word (bank_word),
    .rd_vld    (rd_vld),
    .rd_dout   (rd_dout)
  );

endmodule

`default_nettype wire

// ==== hw/mt_bank_alloc.sv ====
`timescale 1ns/1ps
`default_nettype none

module mt_bank_alloc (
  input  logic                        ready,
  input  mt_pkg::mem_req_t            req     [mt_pkg::NUM_REQ],
  input  mt_pkg::map_row_t            map_in  [mt_pkg::NUM_REQ],
  output mt_pkg::bank_cmd_t           cmd     [mt_pkg::NUM_PBNK],
  output logic [mt_pkg::BITPBNK-1:0]  rd_pbnk,
  output logic [mt_pkg::NUM_WRPT-1:0] upd_vld,
  output logic [mt_pkg::BITVROW-1:0]  upd_row [mt_pkg::NUM_WRPT],
  output mt_pkg::map_row_t            upd_map [mt_pkg::NUM_WRPT]
);
  import mt_pkg::*;

  logic [NUM_REQ-1:0] vld;
  logic [BITVBNK-1:0] vbnk [NUM_REQ];
  logic [BITVROW-1:0] vrow [NUM_REQ];

  function automatic logic in_row(map_row_t row, int pb);
    logic hit;
    hit = 1'b0;
    for (int v = 0; v < NUM_VBNK; v++) begin
      if (row[v] == BITPBNK'(pb)) begin
        hit = 1'b1;
      end
    end
    return hit;
  endfunction

  always_comb begin
    for (int i = 0; i < NUM_REQ; i++) begin
      vbnk[i] = req[i].addr[BITVBNK-1:0];
      vrow[i] = req[i].addr[BITADDR-1:BITVBNK];
      vld[i]  = ready && req[i].vld;
    end
    if (vld[2] && req[1].addr == req[2].addr) begin
      vld[1] = 1'b0;  // write 1 wins on a same-address pair
    end
  end

  // claim order is read, write 0, write 1
  always_comb begin
    logic [NUM_PBNK-1:0] claimed;
    map_row_t            row;
    map_row_t            prev_row;
    logic [BITPBNK-1:0]  pb;
    logic                found;

    claimed  = '0;
    prev_row = map_in[1];
    for (int p = 0; p < NUM_PBNK; p++) begin
      cmd[p] = '0;
    end

    rd_pbnk = map_in[0][vbnk[0]];  // the read never moves
    if (vld[0]) begin
      claimed[rd_pbnk]  = 1'b1;
      cmd[rd_pbnk].read = 1'b1;
      cmd[rd_pbnk].vrow = vrow[0];
    end

    for (int w = 0; w < NUM_WRPT; w++) begin
      row = map_in[w+1];
      if (w == 1 && vld[1] && vrow[1] == vrow[2]) begin
        row = prev_row;  // same row as write 0, start from its remapped row
      end
      pb         = row[vbnk[w+1]];
      found      = 1'b0;
      upd_vld[w] = 1'b0;

      if (vld[w+1] && claimed[pb]) begin
        for (int p = 0; p < NUM_PBNK; p++) begin
          if (!found && !claimed[p] && !in_row(row, p)) begin
            pb    = BITPBNK'(p);  // lowest spare bank of this row
            found = 1'b1;
          end
        end
        row[vbnk[w+1]] = pb;
        upd_vld[w]     = 1'b1;
      end

      if (vld[w+1]) begin
        claimed[pb]    = 1'b1;
        cmd[pb].write  = 1'b1;
        cmd[pb].vrow   = vrow[w+1];
        cmd[pb].data   = req[w+1].data;
      end

      upd_row[w] = vrow[w+1];
      upd_map[w] = row;
      prev_row   = row;
    end
  end

endmodule

`default_nettype wire

// ==== hw/mt_map_table.sv ====
`timescale 1ns/1ps
`default_nettype none

module mt_map_table (
  input  logic                        clk,
  input  logic                        rst,
  input  logic [mt_pkg::BITVROW-1:0]  rd_row  [mt_pkg::NUM_REQ],
  output mt_pkg::map_row_t            map_out [mt_pkg::NUM_REQ],
  input  logic [mt_pkg::NUM_WRPT-1:0] upd_vld,
  input  logic [mt_pkg::BITVROW-1:0]  upd_row [mt_pkg::NUM_WRPT],
  input  mt_pkg::map_row_t            upd_map [mt_pkg::NUM_WRPT],
  output logic                        ready
);
  import mt_pkg::*;

  map_row_t           map_q [NUM_VROW];
  logic [BITVROW-1:0] init_cnt;

  always_comb begin
    for (int i = 0; i < NUM_REQ; i++) begin
      map_out[i] = map_q[rd_row[i]];
    end
  end

  // the sweep writes one row per cycle after reset and ready follows the last row
  always_ff @(posedge clk) begin
    if (rst) begin
      init_cnt <= '0;
      ready    <= 1'b0;
    end else if (!ready) begin
      init_cnt <= init_cnt + 1'b1;
      ready    <= (init_cnt == BITVROW'(NUM_VROW - 1));
    end
  end

  always_ff @(posedge clk) begin
    if (!rst && !ready) begin
      for (int v = 0; v < NUM_VBNK; v++) begin
        map_q[init_cnt][v] <= BITPBNK'(v);  // physical bank equals virtual bank
      end
    end else if (ready) begin
      for (int i = 0; i < NUM_WRPT; i++) begin
        if (upd_vld[i]) begin
          map_q[upd_row[i]] <= upd_map[i];  // write 1 lands last and already carries write 0's move
        end
      end
    end
  end

endmodule

`default_nettype wire

// ==== hw/mt_pkg.sv ====
`default_nettype none

package mt_pkg;

  localparam int WIDTH    = 16;
  localparam int BITADDR  = 6;

  localparam int NUM_VBNK = 4;
  localparam int BITVBNK  = 2;
  localparam int NUM_PBNK = 6;  // two spare banks per virtual row
  localparam int BITPBNK  = 3;
  localparam int NUM_VROW = 16;
  localparam int BITVROW  = 4;

  localparam int NUM_WRDS = 4;  // virtual rows packed side by side in one wide row
  localparam int BITWRDS  = 2;
  localparam int NUM_SROW = 4;
  localparam int BITSROW  = 2;
  localparam int PHYWDTH  = NUM_WRDS * WIDTH;

  localparam int NUM_REQ  = 3;  // read, write 0, write 1 in that order
  localparam int NUM_WRPT = 2;

  typedef struct packed {
    logic               vld;
    logic [BITADDR-1:0] addr;
    logic [WIDTH-1:0]   data;
  } mem_req_t;

  typedef struct packed {
    logic               read;
    logic               write;
    logic [BITVROW-1:0] vrow;
    logic [WIDTH-1:0]   data;
  } bank_cmd_t;

  // entry v holds the physical bank of virtual bank v
  typedef logic [NUM_VBNK-1:0][BITPBNK-1:0] map_row_t;

endpackage

`default_nettype wire

// ==== hw/mt_read_return.sv ====
`timescale 1ns/1ps
`default_nettype none

module mt_read_return (
  input  logic                       clk,
  input  logic                       rst,
  input  logic                       read_fire,
  input  logic [mt_pkg::BITPBNK-1:0] rd_pbnk,
  input  logic [mt_pkg::WIDTH-1:0]   bank_word [mt_pkg::NUM_PBNK],
  output logic                       rd_vld,
  output logic [mt_pkg::WIDTH-1:0]   rd_dout
);
  import mt_pkg::*;

  logic               fire_q;
  logic [BITPBNK-1:0] pbnk_q;

  always_ff @(posedge clk) begin
    if (rst) begin
      fire_q <= 1'b0;
      rd_vld <= 1'b0;
    end else begin
      fire_q <= read_fire;
      rd_vld <= fire_q;  // second cycle after the strobe
    end
  end

  always_ff @(posedge clk) begin
    pbnk_q <= rd_pbnk;  // bank data shows up one cycle after the command
    if (fire_q) begin
      rd_dout <= bank_word[pbnk_q];
    end
  end

endmodule

`default_nettype wire

// ==== hw/mt_word_align.sv ====
`timescale 1ns/1ps
`default_nettype none

module mt_word_align (
  input  logic                       clk,
  input  mt_pkg::bank_cmd_t          cmd,
  output logic                       mem_read,
  output logic                       mem_write,
  output logic [mt_pkg::BITSROW-1:0] mem_addr,
  output logic [mt_pkg::PHYWDTH-1:0] mem_bw,
  output logic [mt_pkg::PHYWDTH-1:0] mem_din,
  input  logic [mt_pkg::PHYWDTH-1:0] mem_dout,
  output logic [mt_pkg::WIDTH-1:0]   dout
);
  import mt_pkg::*;

  logic [BITWRDS-1:0] slot;
  logic [BITWRDS-1:0] slot_q;

  assign slot      = cmd.vrow[BITWRDS-1:0];  // row modulo 4 picks the word slot
  assign mem_read  = cmd.read;
  assign mem_write = cmd.write;
  assign mem_addr  = cmd.vrow[BITVROW-1:BITWRDS];
  assign mem_din   = {NUM_WRDS{cmd.data}};  // the mask keeps only the chosen slot
  assign mem_bw    = {{(PHYWDTH - WIDTH){1'b0}}, {WIDTH{1'b1}}} << (slot * WIDTH);

  // the bank returns data one cycle later, so the slot must follow it
  always_ff @(posedge clk) begin
    if (cmd.read) begin
      slot_q <= slot;
    end
  end

  assign dout = mem_dout[slot_q * WIDTH +: WIDTH];

endmodule

`default_nettype wire

// ==== hw/sram_1rw.sv ====
`timescale 1ns/1ps
`default_nettype none

module sram_1rw (
  input  logic                       clk,
  input  logic                       read,
  input  logic                       write,
  input  logic [mt_pkg::BITSROW-1:0] addr,
  input  logic [mt_pkg::PHYWDTH-1:0] bw,
  input  logic [mt_pkg::PHYWDTH-1:0] din,
  output logic [mt_pkg::PHYWDTH-1:0] dout
);
  import mt_pkg::*;

  logic [PHYWDTH-1:0] mem [NUM_SROW];

  always_ff @(posedge clk) begin
    if (write) begin
      mem[addr] <= (mem[addr] & ~bw) | (din & bw);  // bit mask merge
    end
    if (read) begin
      dout <= mem[addr];
    end
  end

endmodule

`default_nettype wire

// ==== run.sh ====
#!/bin/sh
# runs from the project root so the trace path resolves
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing -Wno-fatal --top-module tb_mt_1r2w -f all.f -o tb_sim &&
  ./obj_dir/tb_sim > sim.log 2>&1 ||
  { cat sim.log 2>/dev/null; echo "build or run error"; exit 1; }
cat sim.log
grep -q "Simulation failed" sim.log && exit 1 || exit 0

// ==== tb/mt_1r2w_trace.txt ====
# read rd_addr wr0 wr0_addr wr0_din wr1 wr1_addr wr1_din exp_data, all hex, one line per cycle
# a line starting with "test" opens a new test section
test plain_write_read
0 00 1 00 1100 1 01 1101 0000
0 00 1 02 1102 1 03 1103 0000
0 00 1 04 1204 1 3f 1f3f 0000
0 00 1 3c 1f3c 1 3d 1f3d 0000
1 00 0 00 0000 0 00 0000 1100
1 01 0 00 0000 0 00 0000 1101
1 02 0 00 0000 0 00 0000 1102
1 03 0 00 0000 0 00 0000 1103
1 04 0 00 0000 0 00 0000 1204
1 3f 0 00 0000 0 00 0000 1f3f
1 3c 0 00 0000 0 00 0000 1f3c
1 3d 0 00 0000 0 00 0000 1f3d
test read_write_collision
0 00 1 08 2208 1 09 2209 0000
0 00 1 0c 230c 1 0d 230d 0000
1 08 1 08 3208 1 0c 330c 2208
1 08 0 00 0000 0 00 0000 3208
1 0c 0 00 0000 0 00 0000 330c
1 09 0 00 0000 0 00 0000 2209
1 0d 0 00 0000 0 00 0000 230d
1 08 1 08 4208 1 0c 430c 3208
1 08 0 00 0000 0 00 0000 4208
1 0c 0 00 0000 0 00 0000 430c
test same_address_writes
0 00 1 10 5010 1 10 5110 0000
1 10 0 00 0000 0 00 0000 5110
1 10 1 10 6010 1 10 6110 5110
1 10 0 00 0000 0 00 0000 6110
test word_packing
0 00 1 21 7021 1 22 7022 0000
0 00 1 25 7025 0 00 0000 0000
0 00 1 29 7029 0 00 0000 0000
0 00 1 2d 702d 0 00 0000 0000
1 21 0 00 0000 0 00 0000 7021
1 25 0 00 0000 0 00 0000 7025
1 29 0 00 0000 0 00 0000 7029
1 2d 0 00 0000 0 00 0000 702d
1 22 0 00 0000 0 00 0000 7022
test continuous_reads
1 00 1 30 9030 0 00 0000 1100
1 3f 0 00 0000 0 00 0000 1f3f
1 08 0 00 0000 0 00 0000 4208
1 10 0 00 0000 0 00 0000 6110
1 2d 0 00 0000 0 00 0000 702d
1 30 0 00 0000 0 00 0000 9030

// ==== tb/tb_clock.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_clock (
  output logic clk
);

  localparam int HALF_PERIOD = 50;  // 100 ns period

  initial begin
    clk = 1'b0;
    forever #(HALF_PERIOD) clk = ~clk;
  end

endmodule

`default_nettype wire

// ==== tb/tb_mt_1r2w.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_mt_1r2w;
  import mt_pkg::*;

  localparam int DRIVE_DELAY   = 10;  // ns after the rising edge
  localparam int RESET_CYCLES  = 2;
  localparam int READY_TIMEOUT = 100;
  localparam int DRAIN_TIMEOUT = 8;

  typedef struct packed {
    mem_req_t         rd;  // data field is not used on the read port
    mem_req_t         wr0;
    mem_req_t         wr1;
    logic [WIDTH-1:0] exp_data;
  } trace_line_t;

  logic               clk;
  logic               rst;
  logic               read;
  logic [BITADDR-1:0] rd_addr;
  logic               wr0;
  logic [BITADDR-1:0] wr0_addr;
  logic [WIDTH-1:0]   wr0_din;
  logic               wr1;
  logic [BITADDR-1:0] wr1_addr;
  logic [WIDTH-1:0]   wr1_din;
  logic               rd_vld;
  logic [WIDTH-1:0]   rd_dout;
  logic               ready;

  logic [WIDTH-1:0] exp_q [$];
  logic [1:0]       due;  // read strobes of the last two lines, bit 1 is the older one
  string            test_name;
  int               errors;
  int               checks;
  int               test_errors;
  int               test_checks;
  int               tests;
  int               failed_tests;
  bit               aborted;

  tb_clock u_clock (.clk(clk));

  mt_1r2w_top u_dut (
    .clk      (clk),
    .rst      (rst),
    .read     (read),
    .rd_addr  (rd_addr),
    .wr0      (wr0),
    .wr0_addr (wr0_addr),
    .wr0_din  (wr0_din),
    .wr1      (wr1),
    .wr1_addr (wr1_addr),
    .wr1_din  (wr1_din),
    .rd_vld   (rd_vld),
    .rd_dout  (rd_dout),
    .ready    (ready)
  );

  task automatic drive_inputs(input trace_line_t ln);
    read     = ln.rd.vld;
    rd_addr  = ln.rd.addr;
    wr0      = ln.wr0.vld;
    wr0_addr = ln.wr0.addr;
    wr0_din  = ln.wr0.data;
    wr1      = ln.wr1.vld;
    wr1_addr = ln.wr1.addr;
    wr1_din  = ln.wr1.data;
  endtask

  task automatic note_error;
    errors++;
    test_errors++;
  endtask

  task automatic check_read;
    logic [WIDTH-1:0] exp_data;
    if (due[1]) begin
      exp_data = exp_q.pop_front();
      checks++;
      test_checks++;
      if (rd_vld !== 1'b1) begin
        $display("read valid missing at %0t ns, two cycles after a read strobe", $time);
        note_error();
      end else if (rd_dout !== exp_data) begin
        $display("FAILED at %0t ns: read data %h, expected %h", $time, rd_dout, exp_data);
        note_error();
      end
    end else if (rd_vld !== 1'b0) begin
      $display("read valid at %0t ns without a read strobe two cycles earlier", $time);
      note_error();
    end
  endtask

  // registered outputs are settled well before the new inputs go out
  task automatic step_cycle(input trace_line_t ln);
    @(posedge clk);
    #(DRIVE_DELAY);
    check_read();
    drive_inputs(ln);
    due = {due[0], ln.rd.vld};
    if (ln.rd.vld) begin
      exp_q.push_back(ln.exp_data);
    end
  endtask

  task automatic drain_reads;
    int cycles;
    cycles = 0;
    while (exp_q.size() != 0 && cycles < DRAIN_TIMEOUT) begin
      step_cycle('0);
      cycles++;
    end
    if (exp_q.size() != 0) begin
      $display("reads still pending after %0d idle cycles", DRAIN_TIMEOUT);
      note_error();
      aborted = 1'b1;
    end
  endtask

  task automatic start_test(input string name);
    test_name   = name;
    test_errors = 0;
    test_checks = 0;
  endtask

  task automatic finish_test;
    tests++;
    if (test_errors != 0) begin
      failed_tests++;
    end
    $display("test %s: %0d checks, %0d errors", test_name, test_checks, test_errors);
  endtask

  task automatic reset_and_init;
    int cycles;
    start_test("reset_init");
    rst  = 1'b1;
    read = 1'b1;  // a strobe held through reset and the sweep must never fire
    for (int i = 0; i < RESET_CYCLES; i++) begin
      @(posedge clk);
      #(DRIVE_DELAY);
      checks++;
      test_checks++;
      if (ready !== 1'b0 || rd_vld !== 1'b0) begin
        $display("FAILED at %0t ns: ready %b rd_vld %b in reset", $time, ready, rd_vld);
        note_error();
      end
    end
    rst    = 1'b0;
    cycles = 0;
    while (ready !== 1'b1 && cycles < READY_TIMEOUT) begin
      @(posedge clk);
      #(DRIVE_DELAY);
      cycles++;
      if (rd_vld !== 1'b0) begin
        $display("FAILED at %0t ns: rd_vld high during the table sweep", $time);
        note_error();
      end
    end
    read = 1'b0;
    checks++;
    test_checks++;
    if (ready !== 1'b1) begin
      $display("ready did not rise within %0d cycles after reset", READY_TIMEOUT);
      note_error();
      aborted = 1'b1;
    end else if (cycles != NUM_VROW) begin
      $display("FAILED at %0t ns: ready after %0d cycles, expected %0d", $time, cycles, NUM_VROW);
      note_error();
    end
    finish_test();
  endtask

  task automatic run_trace;
    int           fd;
    int           code;
    string        line;
    logic [255:0] name;
    logic [31:0]  f [9];
    trace_line_t  ln;
    bit           in_test;
    in_test = 1'b0;
    fd = $fopen("tb/mt_1r2w_trace.txt", "r");
    if (fd == 0) begin
      $display("cannot open the trace file tb/mt_1r2w_trace.txt");
      note_error();
      aborted = 1'b1;
      return;
    end
    while (!aborted) begin
      code = $fgets(line, fd);
      if (code == 0) begin
        break;
      end
      if (line.len() < 2 || line.getc(0) == "#") begin
        continue;
      end
      if (line.getc(0) == "t") begin
        if (in_test) begin
          drain_reads();
          finish_test();
        end
        code = $sscanf(line, "test %s", name);
        start_test($sformatf("%0s", name));
        in_test = !aborted;
      end else begin
        code = $sscanf(line, "%h %h %h %h %h %h %h %h %h",
                       f[0], f[1], f[2], f[3], f[4], f[5], f[6], f[7], f[8]);
        if (code != 9) begin
          $display("trace line could not be parsed: %s", line);
          note_error();
        end else begin
          ln.rd       = '{vld: f[0][0], addr: f[1][BITADDR-1:0], data: '0};
          ln.wr0      = '{vld: f[2][0], addr: f[3][BITADDR-1:0], data: f[4][WIDTH-1:0]};
          ln.wr1      = '{vld: f[5][0], addr: f[6][BITADDR-1:0], data: f[7][WIDTH-1:0]};
          ln.exp_data = f[8][WIDTH-1:0];
          step_cycle(ln);
        end
      end
    end
    if (in_test) begin
      if (!aborted) begin
        drain_reads();
      end
      finish_test();
    end
    $fclose(fd);
  endtask

  initial begin
    drive_inputs('0);
    rst          = 1'b1;
    due          = '0;
    errors       = 0;
    checks       = 0;
    tests        = 0;
    failed_tests = 0;
    aborted      = 1'b0;
    reset_and_init();
    if (!aborted) begin
      run_trace();
    end
    $display("tests %0d, tests with errors %0d, checks %0d, errors %0d",
             tests, failed_tests, checks, errors);
    if (errors == 0 && !aborted) begin
      $display("Simulation completed successfully");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

`default_nettype wire
